// File: files.f
hdl/wb_pkg.sv
hdl/wb_port_if.sv
hdl/ex2_wb_stage.sv
hdl/divider.sv
hdl/regfile.sv
hdl/exc_csr.sv
hdl/wb_top.sv
testbench/wb_checker.sv
testbench/tb_wb_top.sv

// File: hdl/divider.sv
`timescale 1ns/10ps

module divider #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            aresetn,
    input  logic            div_start,
    input  logic [XLEN-1:0] div_dividend,
    input  logic [XLEN-1:0] div_divisor,
    output logic            div_ready,
    output logic [XLEN-1:0] quotient,
    output logic [XLEN-1:0] remainder
);
    localparam int CNT_W = $clog2(XLEN + 1);

    logic             busy;
    logic [CNT_W-1:0] count;
    logic [XLEN-1:0]  divisor_q;
    logic [XLEN:0]    shifted;
    logic [XLEN+1:0]  trial;

    // bring down the next dividend bit, then try the subtraction
    assign shifted = {remainder, quotient[XLEN-1]};
    assign trial   = {1'b0, shifted} - {2'b00, divisor_q};

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            busy      <= 1'b0;
            count     <= '0;
            div_ready <= 1'b0;
        end else begin
            div_ready <= 1'b0;
            if (div_start) begin
                busy  <= 1'b1;
                count <= CNT_W'(XLEN);
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == CNT_W'(1)) begin
                    busy      <= 1'b0;
                    div_ready <= 1'b1;
                end
            end
        end
    end

    // a zero divisor never fails the trial, so the quotient fills with ones
    // and the remainder collects the dividend
    always_ff @(posedge clk) begin
        if (div_start) begin
            quotient  <= div_dividend;
            remainder <= '0;
            divisor_q <= div_divisor;
        end else if (busy) begin
            if (!trial[XLEN+1]) begin
                remainder <= trial[XLEN-1:0];
                quotient  <= {quotient[XLEN-2:0], 1'b1};
            end else begin
                remainder <= shifted[XLEN-1:0];
                quotient  <= {quotient[XLEN-2:0], 1'b0};
            end
        end
    end

endmodule

// File: hdl/ex2_wb_stage.sv
`timescale 1ns/10ps

module ex2_wb_stage #(
    parameter int XLEN = 32
) (
    input  logic                          clk,
    input  logic                          aresetn,
    input  wb_pkg::uop_t                  uop0,
    input  wb_pkg::uop_t                  uop1,
    input  logic [wb_pkg::ADDR_W-1:0]     pc0,
    input  logic [wb_pkg::ADDR_W-1:0]     pc1,
    input  logic [XLEN-1:0]               result0,
    input  logic [XLEN-1:0]               result1,
    input  logic                          result0_valid,
    input  logic                          result1_valid,
    input  logic [wb_pkg::REG_ADDR_W-1:0] rd0,
    input  logic [wb_pkg::REG_ADDR_W-1:0] rd1,
    input  logic [XLEN-1:0]               csr_data,
    input  logic                          csr_ready,
    input  logic [XLEN-1:0]               src_a0,
    input  logic [XLEN-1:0]               src_b0,
    input  logic [XLEN-1:0]               src_a1,
    input  logic [XLEN-1:0]               src_b1,
    input  logic                          load_pending,
    input  logic                          dcache_ready,
    input  logic                          dcache_w_ready,
    input  logic [XLEN-1:0]               dcache_data,
    input  logic [wb_pkg::REG_ADDR_W-1:0] dcache_rd,
    input  logic [wb_pkg::ADDR_W-1:0]     load_pc,
    input  logic                          exception_in,
    input  wb_pkg::ecode_t                ecode_in,
    input  logic [wb_pkg::ADDR_W-1:0]     badv_in,
    input  logic [wb_pkg::ADDR_W-1:0]     era_in,
    input  logic                          cpu_interrupt,
    input  logic                          div_ready,
    input  logic [XLEN-1:0]               quotient,
    input  logic [XLEN-1:0]               remainder,
    output logic                          ex2_allowin,
    output logic                          flush,
    output logic                          div_start,
    output logic [XLEN-1:0]               div_dividend,
    output logic [XLEN-1:0]               div_divisor,
    output logic                          exc_commit,
    output wb_pkg::ecode_t                exc_ecode,
    output logic [wb_pkg::ADDR_W-1:0]     exc_badv,
    output logic [wb_pkg::ADDR_W-1:0]     exc_era,
    output logic                          wen_badv,
    output logic                          wen_vppn,
    output logic                          tlb_exc,
    wb_port_if.source                     wb0,
    wb_port_if.source                     wb1,
    wb_port_if.source                     wb2
);
    import wb_pkg::*;

    logic            div_wait0;
    logic            div_wait1;
    logic            div_hit0;
    logic            div_hit1;
    logic            div_started;
    logic            div_lane;
    logic            div_done0;
    logic            div_done1;
    logic [XLEN-1:0] div_hold0;
    logic [XLEN-1:0] div_hold1;
    logic [XLEN-1:0] div_val0;
    logic [XLEN-1:0] div_val1;
    logic [XLEN:0]   sel0;
    logic [XLEN:0]   sel1;
    logic            exc_flag;
    logic            set_badv;
    logic            set_vppn;

    // returns {we, data}, highest priority source first
    function automatic logic [XLEN:0] pick_lane(
        input uop_t            uop,
        input logic            res_valid,
        input logic [XLEN-1:0] res,
        input logic            csr_ok,
        input logic [XLEN-1:0] csr_val,
        input logic            div_ok,
        input logic [XLEN-1:0] div_val
    );
        if (res_valid && !uop.is_load) begin
            return {1'b1, uop.is_link ? res + XLEN'(4) : res};
        end else if (csr_ok) begin
            return {1'b1, csr_val};
        end else if (div_ok) begin
            return {1'b1, div_val};
        end
        return '0;
    endfunction

    // a lane still owes a division result
    assign div_wait0 = uop0.is_div && !result0_valid && !div_done0;
    assign div_wait1 = uop1.is_div && !result1_valid && !div_done1;
    assign div_hit0  = div_ready && !div_lane && div_wait0;
    assign div_hit1  = div_ready && div_lane && div_wait1;

    assign ex2_allowin = !((div_wait0 && !div_hit0) || (div_wait1 && !div_hit1)
                           || (load_pending && !dcache_ready));

    assign div_val0 = div_done0 ? div_hold0 : (uop0.div_rem ? remainder : quotient);
    assign div_val1 = div_done1 ? div_hold1 : (uop1.div_rem ? remainder : quotient);

    assign sel0 = pick_lane(uop0, result0_valid, result0, uop0.is_csr && csr_ready,
                            csr_data, div_hit0 || div_done0, div_val0);
    // no csr path on lane 1
    assign sel1 = pick_lane(uop1, result1_valid, result1, 1'b0,
                            csr_data, div_hit1 || div_done1, div_val1);

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            div_start   <= 1'b0;
            div_started <= 1'b0;
            div_lane    <= 1'b0;
            div_done0   <= 1'b0;
            div_done1   <= 1'b0;
        end else begin
            div_start <= 1'b0;
            if (div_ready) begin
                div_started <= 1'b0;
            end else if (!div_started && (div_wait0 || div_wait1)) begin
                div_start   <= 1'b1;
                div_started <= 1'b1;
                div_lane    <= !div_wait0;
            end
            // keep a finished result while the pair is still stalled
            if (ex2_allowin) begin
                div_done0 <= 1'b0;
                div_done1 <= 1'b0;
            end else begin
                if (div_hit0) begin
                    div_done0 <= 1'b1;
                end
                if (div_hit1) begin
                    div_done1 <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!div_started) begin
            div_dividend <= div_wait0 ? src_a0 : src_a1;
            div_divisor  <= div_wait0 ? src_b0 : src_b1;
        end
        if (div_hit0) begin
            div_hold0 <= div_val0;
        end
        if (div_hit1) begin
            div_hold1 <= div_val1;
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            wb0.we <= 1'b0;
            wb1.we <= 1'b0;
            wb2.we <= 1'b0;
        end else begin
            wb0.we <= ex2_allowin && sel0[XLEN];
            wb1.we <= ex2_allowin && sel1[XLEN];
            wb2.we <= dcache_w_ready;
        end
    end

    always_ff @(posedge clk) begin
        wb0.data <= sel0[XLEN-1:0];
        wb0.rd   <= rd0;
        wb0.pc   <= pc0;
        wb1.data <= sel1[XLEN-1:0];
        wb1.rd   <= rd1;
        wb1.pc   <= pc1;
        wb2.data <= dcache_data;
        wb2.rd   <= dcache_rd;
        wb2.pc   <= load_pc;
    end

    // codes that report a faulting address
    assign set_badv = ecode_in inside {ECODE_PIL, ECODE_PIS, ECODE_PIF, ECODE_PME,
                                       ECODE_PPI, ECODE_ADEF, ECODE_ALE, ECODE_TLBR};
    assign set_vppn = ecode_in inside {ECODE_PIL, ECODE_PIS, ECODE_PIF, ECODE_PME,
                                       ECODE_PPI, ECODE_TLBR};

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            exc_flag <= 1'b0;
            wen_badv <= 1'b0;
            wen_vppn <= 1'b0;
            tlb_exc  <= 1'b0;
        end else begin
            exc_flag <= ex2_allowin && (exception_in || cpu_interrupt);
            wen_badv <= ex2_allowin && exception_in && set_badv;
            wen_vppn <= ex2_allowin && exception_in && set_vppn;
            tlb_exc  <= ex2_allowin && exception_in && (ecode_in == ECODE_TLBR);
        end
    end

    always_ff @(posedge clk) begin
        // interrupt alone reports INT
        exc_ecode <= exception_in ? ecode_in : ECODE_INT;
        exc_badv  <= badv_in;
        exc_era   <= era_in;
    end

    assign flush      = exc_flag;
    assign exc_commit = exc_flag;

endmodule

// File: hdl/exc_csr.sv
`timescale 1ns/10ps

module exc_csr (
    input  logic                      clk,
    input  logic                      aresetn,
    input  logic                      exc_commit,
    input  wb_pkg::ecode_t            exc_ecode,
    input  logic [wb_pkg::ADDR_W-1:0] exc_badv,
    input  logic [wb_pkg::ADDR_W-1:0] exc_era,
    input  logic                      wen_badv,
    input  logic                      wen_vppn,
    input  logic                      tlb_exc,
    input  logic [wb_pkg::ADDR_W-1:0] eentry,
    input  logic [wb_pkg::ADDR_W-1:0] tlbrentry,
    output logic [wb_pkg::ADDR_W-1:0] csr_era,
    output logic [wb_pkg::ADDR_W-1:0] csr_badv,
    output logic [wb_pkg::VPPN_W-1:0] csr_vppn,
    output wb_pkg::ecode_t            csr_ecode,
    output logic [wb_pkg::ADDR_W-1:0] redirect_pc
);
    import wb_pkg::*;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            csr_era   <= '0;
            csr_badv  <= '0;
            csr_vppn  <= '0;
            csr_ecode <= ECODE_INT;
        end else begin
            if (exc_commit) begin
                csr_era   <= exc_era;
                csr_ecode <= exc_ecode;
            end
            if (wen_badv) begin
                csr_badv <= exc_badv;
            end
            // virtual page number of the faulting address
            if (wen_vppn) begin
                csr_vppn <= exc_badv[ADDR_W-1 -: VPPN_W];
            end
        end
    end

    // tlb refill has its own entry point
    assign redirect_pc = tlb_exc ? tlbrentry : eentry;

endmodule

// File: hdl/regfile.sv
`timescale 1ns/10ps

module regfile #(
    parameter int XLEN = 32
) (
    input  logic                          clk,
    input  logic                          aresetn,
    wb_port_if.sink                       wb0,
    wb_port_if.sink                       wb1,
    wb_port_if.sink                       wb2,
    input  logic [wb_pkg::REG_ADDR_W-1:0] rf_raddr,
    output logic [XLEN-1:0]               rf_rdata
);
    logic [XLEN-1:0] regs [32];

    // later ports overwrite earlier ones on the same register
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb0.we && wb0.rd != '0) begin
                regs[wb0.rd] <= wb0.data;
            end
            if (wb1.we && wb1.rd != '0) begin
                regs[wb1.rd] <= wb1.data;
            end
            if (wb2.we && wb2.rd != '0) begin
                regs[wb2.rd] <= wb2.data;
            end
        end
    end

    assign rf_rdata = (rf_raddr == '0) ? '0 : regs[rf_raddr];

endmodule

// File: hdl/wb_pkg.sv
package wb_pkg;

    localparam int REG_ADDR_W = 5;
    localparam int VPPN_W     = 19;
    localparam int ADDR_W     = 32;

    typedef logic [6:0] ecode_t;

    localparam ecode_t ECODE_INT  = 7'h00;
    localparam ecode_t ECODE_PIL  = 7'h01;
    localparam ecode_t ECODE_PIS  = 7'h02;
    localparam ecode_t ECODE_PIF  = 7'h03;
    localparam ecode_t ECODE_PME  = 7'h04;
    localparam ecode_t ECODE_PPI  = 7'h07;
    localparam ecode_t ECODE_ADEF = 7'h08;
    localparam ecode_t ECODE_ALE  = 7'h09;
    // syscall, carries no bad address
    localparam ecode_t ECODE_SYS  = 7'h0b;
    localparam ecode_t ECODE_TLBR = 7'h3f;

    // micro-op flags seen by writeback
    typedef struct packed {
        logic is_csr;
        logic is_div;
        // 1 selects the remainder
        logic div_rem;
        logic is_link;
        logic is_load;
    } uop_t;

endpackage

// File: hdl/wb_port_if.sv
`timescale 1ns/10ps

interface wb_port_if #(
    parameter int XLEN = 32
);
    import wb_pkg::*;

    logic                  we;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
    logic [ADDR_W-1:0]     pc;

    modport source (output we, rd, data, pc);
    modport sink   (input  we, rd, data, pc);

endinterface

// File: hdl/wb_top.sv
`timescale 1ns/10ps

module wb_top #(
    parameter int XLEN = 32
) (
    input  logic                          clk,
    input  logic                          aresetn,
    input  wb_pkg::uop_t                  uop0,
    input  wb_pkg::uop_t                  uop1,
    input  logic [wb_pkg::ADDR_W-1:0]     pc0,
    input  logic [wb_pkg::ADDR_W-1:0]     pc1,
    input  logic [XLEN-1:0]               result0,
    input  logic [XLEN-1:0]               result1,
    input  logic                          result0_valid,
    input  logic                          result1_valid,
    input  logic [wb_pkg::REG_ADDR_W-1:0] rd0,
    input  logic [wb_pkg::REG_ADDR_W-1:0] rd1,
    input  logic [XLEN-1:0]               csr_data,
    input  logic                          csr_ready,
    input  logic [XLEN-1:0]               src_a0,
    input  logic [XLEN-1:0]               src_b0,
    input  logic [XLEN-1:0]               src_a1,
    input  logic [XLEN-1:0]               src_b1,
    input  logic                          load_pending,
    input  logic                          dcache_ready,
    input  logic                          dcache_w_ready,
    input  logic [XLEN-1:0]               dcache_data,
    input  logic [wb_pkg::REG_ADDR_W-1:0] dcache_rd,
    input  logic [wb_pkg::ADDR_W-1:0]     load_pc,
    input  logic                          exception_in,
    input  wb_pkg::ecode_t                ecode_in,
    input  logic [wb_pkg::ADDR_W-1:0]     badv_in,
    input  logic [wb_pkg::ADDR_W-1:0]     era_in,
    input  logic                          cpu_interrupt,
    input  logic [wb_pkg::ADDR_W-1:0]     eentry,
    input  logic [wb_pkg::ADDR_W-1:0]     tlbrentry,
    input  logic [wb_pkg::REG_ADDR_W-1:0] rf_raddr,
    output logic                          ex2_allowin,
    output logic                          flush,
    output logic [wb_pkg::ADDR_W-1:0]     redirect_pc,
    output logic [wb_pkg::ADDR_W-1:0]     csr_era,
    output logic [wb_pkg::ADDR_W-1:0]     csr_badv,
    output logic [wb_pkg::VPPN_W-1:0]     csr_vppn,
    output wb_pkg::ecode_t                csr_ecode,
    output logic [XLEN-1:0]               rf_rdata,
    output logic                          wb0_we,
    output logic [wb_pkg::REG_ADDR_W-1:0] wb0_rd,
    output logic [XLEN-1:0]               wb0_data,
    output logic [wb_pkg::ADDR_W-1:0]     wb0_pc,
    output logic                          wb1_we,
    output logic [wb_pkg::REG_ADDR_W-1:0] wb1_rd,
    output logic [XLEN-1:0]               wb1_data,
    output logic [wb_pkg::ADDR_W-1:0]     wb1_pc,
    output logic                          wb2_we,
    output logic [wb_pkg::REG_ADDR_W-1:0] wb2_rd,
    output logic [XLEN-1:0]               wb2_data,
    output logic [wb_pkg::ADDR_W-1:0]     wb2_pc
);
    import wb_pkg::*;

    logic              div_start;
    logic [XLEN-1:0]   div_dividend;
    logic [XLEN-1:0]   div_divisor;
    logic              div_ready;
    logic [XLEN-1:0]   quotient;
    logic [XLEN-1:0]   remainder;
    logic              exc_commit;
    ecode_t            exc_ecode;
    logic [ADDR_W-1:0] exc_badv;
    logic [ADDR_W-1:0] exc_era;
    logic              wen_badv;
    logic              wen_vppn;
    logic              tlb_exc;

    wb_port_if #(.XLEN(XLEN)) wb0 ();
    wb_port_if #(.XLEN(XLEN)) wb1 ();
    wb_port_if #(.XLEN(XLEN)) wb2 ();

    // names match one to one with the stage ports
    ex2_wb_stage #(.XLEN(XLEN)) u_stage (.*);

    divider #(.XLEN(XLEN)) u_divider (
        .clk          (clk),
        .aresetn      (aresetn),
        .div_start    (div_start),
        .div_dividend (div_dividend),
        .div_divisor  (div_divisor),
        .div_ready    (div_ready),
        .quotient     (quotient),
        .remainder    (remainder)
    );

    regfile #(.XLEN(XLEN)) u_regfile (
        .clk      (clk),
        .aresetn  (aresetn),
        .wb0      (wb0.sink),
        .wb1      (wb1.sink),
        .wb2      (wb2.sink),
        .rf_raddr (rf_raddr),
        .rf_rdata (rf_rdata)
    );

    exc_csr u_exc_csr (
        .clk         (clk),
        .aresetn     (aresetn),
        .exc_commit  (exc_commit),
        .exc_ecode   (exc_ecode),
        .exc_badv    (exc_badv),
        .exc_era     (exc_era),
        .wen_badv    (wen_badv),
        .wen_vppn    (wen_vppn),
        .tlb_exc     (tlb_exc),
        .eentry      (eentry),
        .tlbrentry   (tlbrentry),
        .csr_era     (csr_era),
        .csr_badv    (csr_badv),
        .csr_vppn    (csr_vppn),
        .csr_ecode   (csr_ecode),
        .redirect_pc (redirect_pc)
    );

    // write ports brought out for observation
    assign wb0_we   = wb0.we;
    assign wb0_rd   = wb0.rd;
    assign wb0_data = wb0.data;
    assign wb0_pc   = wb0.pc;
    assign wb1_we   = wb1.we;
    assign wb1_rd   = wb1.rd;
    assign wb1_data = wb1.data;
    assign wb1_pc   = wb1.pc;
    assign wb2_we   = wb2.we;
    assign wb2_rd   = wb2.rd;
    assign wb2_data = wb2.data;
    assign wb2_pc   = wb2.pc;

endmodule

// File: testbench/tb_wb_top.sv
`timescale 1ns/10ps

module tb_wb_top;
    import wb_pkg::*;

    localparam int XLEN  = 32;
    localparam int NROWS = 21;
    localparam int K_ALU = 0;
    localparam int K_CSR = 1;
    localparam int K_CSRW = 2;
    localparam int K_DIV0 = 3;
    localparam int K_DIV1 = 4;
    localparam int K_LOAD = 5;
    localparam int K_EXC = 6;
    localparam int K_INT = 7;
    localparam logic [ADDR_W-1:0] PC0     = 32'h1c000100;
    localparam logic [ADDR_W-1:0] PC1     = 32'h1c000104;
    localparam logic [ADDR_W-1:0] LOAD_PC = 32'h1c000200;

    // fl is {link0, link1, div_rem, zero divisor}
    typedef struct {
        int                kind;
        logic [3:0]        fl;
        logic [4:0]        rd0;
        logic [XLEN-1:0]   v0;
        logic [XLEN-1:0]   e0;
        logic [4:0]        rd1;
        logic [XLEN-1:0]   v1;
        logic [XLEN-1:0]   e1;
        ecode_t            ecode;
        logic [ADDR_W-1:0] addr;
    } row_t;

    logic clk, aresetn;
    uop_t uop0, uop1;
    logic [ADDR_W-1:0] pc0, pc1, load_pc, badv_in, era_in, eentry, tlbrentry, redirect_pc;
    logic [ADDR_W-1:0] csr_era, csr_badv, wb0_pc, wb1_pc, wb2_pc;
    logic [XLEN-1:0] result0, result1, csr_data, src_a0, src_b0, src_a1, src_b1, dcache_data;
    logic [XLEN-1:0] rf_rdata, wb0_data, wb1_data, wb2_data;
    logic result0_valid, result1_valid, csr_ready, load_pending, dcache_ready, dcache_w_ready;
    logic exception_in, cpu_interrupt, ex2_allowin, flush, wb0_we, wb1_we, wb2_we;
    logic [REG_ADDR_W-1:0] rd0, rd1, dcache_rd, rf_raddr, wb0_rd, wb1_rd, wb2_rd;
    ecode_t ecode_in, csr_ecode;
    logic [VPPN_W-1:0] csr_vppn;

    row_t   rows [NROWS];
    row_t   row;
    integer seed = 32'hda9c0dbf;
    logic [XLEN-1:0] e0, e1;
    logic   we0, we1;

    wb_top #(.XLEN(XLEN)) UUT (.*);
    wb_checker #(.XLEN(XLEN)) chk (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // the longest row is a division of XLEN steps plus a few cycles around it
    initial begin
        repeat (NROWS * (XLEN + 6) + 8) @(posedge clk);
        $display("run timed out before all table rows were applied");
        $display("Regression failed");
        $finish;
    end

    function automatic row_t mk(int kind, logic [3:0] fl, logic [4:0] r0, logic [31:0] v0,
                                logic [31:0] x0, logic [4:0] r1, logic [31:0] v1,
                                logic [31:0] x1, ecode_t ec, logic [31:0] addr);
        row_t r;
        r = '{kind, fl, r0, v0, x0, r1, v1, x1, ec, addr};
        return r;
    endfunction

    task automatic fill_table();
        rows[0]  = mk(K_ALU, 4'b0000, 3, 32'h11111111, 32'h11111111, 4, 32'h22222222,
                      32'h22222222, ECODE_SYS, 0);
        rows[1]  = mk(K_ALU, 4'b1000, 5, 32'h00001000, 32'h00001004, 6, 32'h00002000,
                      32'h00002000, ECODE_SYS, 0);
        rows[2]  = mk(K_ALU, 4'b0100, 0, 32'hdeadbeef, 32'hdeadbeef, 7, 32'hfffffffc,
                      32'h00000000, ECODE_SYS, 0);
        rows[3]  = mk(K_CSR, 4'b0000, 8, 32'hcafe0001, 32'hcafe0001, 9, 0, 0, ECODE_SYS, 0);
        rows[4]  = mk(K_CSRW, 4'b0000, 10, 32'hcafe0002, 0, 0, 0, 0, ECODE_SYS, 0);
        rows[5]  = mk(K_DIV0, 4'b0000, 11, 0, 0, 0, 0, 0, ECODE_SYS, 0);
        rows[6]  = mk(K_DIV0, 4'b0010, 12, 0, 0, 0, 0, 0, ECODE_SYS, 0);
        rows[7]  = mk(K_DIV1, 4'b0000, 0, 0, 0, 13, 0, 0, ECODE_SYS, 0);
        rows[8]  = mk(K_DIV0, 4'b0001, 14, 0, 0, 0, 0, 0, ECODE_SYS, 0);
        rows[9]  = mk(K_DIV1, 4'b0011, 0, 0, 0, 15, 0, 0, ECODE_SYS, 0);
        rows[10] = mk(K_LOAD, 4'b0000, 16, 32'h00001234, 32'h00001234, 0, 32'h5a5a5a5a,
                      0, ECODE_SYS, 0);
        rows[11] = mk(K_EXC, 0, 0, 0, 0, 0, 0, 0, ECODE_PIL, 32'h12345678);
        rows[12] = mk(K_EXC, 0, 0, 0, 0, 0, 0, 0, ECODE_PIS, 32'h2000a000);
        rows[13] = mk(K_EXC, 0, 0, 0, 0, 0, 0, 0, ECODE_SYS, 32'h99990000);
        rows[14] = mk(K_EXC, 0, 0, 0, 0, 0, 0, 0, ECODE_PIF, 32'h3000c004);
        rows[15] = mk(K_EXC, 0, 0, 0, 0, 0, 0, 0, ECODE_PME, 32'h40006008);
        rows[16] = mk(K_EXC, 0, 0, 0, 0, 0, 0, 0, ECODE_PPI, 32'h5000e010);
        rows[17] = mk(K_EXC, 0, 0, 0, 0, 0, 0, 0, ECODE_ADEF, 32'h6000f001);
        rows[18] = mk(K_EXC, 0, 0, 0, 0, 0, 0, 0, ECODE_TLBR, 32'h7fff2000);
        rows[19] = mk(K_EXC, 0, 0, 0, 0, 0, 0, 0, ECODE_ALE, 32'h8000a003);
        rows[20] = mk(K_INT, 0, 0, 0, 0, 0, 0, 0, ECODE_ALE, 32'h0bad0bad);
    endtask

    task automatic idle_inputs();
        uop0 = '0;
        uop1 = '0;
        {pc0, pc1, result0, result1, result0_valid, result1_valid, rd0, rd1} = '0;
        {csr_data, csr_ready, src_a0, src_b0, src_a1, src_b1} = '0;
        {load_pending, dcache_w_ready, dcache_data, dcache_rd, load_pc} = '0;
        {exception_in, ecode_in, badv_in, era_in, cpu_interrupt, rf_raddr} = '0;
        dcache_ready = 1'b1;
        eentry    = 32'h1c000000;
        tlbrentry = 32'h1c001000;
    endtask

    // drives one row, returns the expected lane values
    task automatic drive_row(input row_t r, output logic [XLEN-1:0] x0,
                             output logic [XLEN-1:0] x1);
        logic [XLEN-1:0] a, b, q;
        a  = $random(seed);
        b  = r.fl[0] ? '0 : (($random(seed) & 32'h0000ffff) | 32'h1);
        q  = (b == 0) ? '1 : a / b;
        x0 = r.e0;
        x1 = r.e1;
        pc0 = PC0;
        pc1 = PC1;
        rd0 = r.rd0;
        rd1 = r.rd1;
        case (r.kind)
            K_ALU, K_LOAD: begin
                {uop0.is_link, uop1.is_link} = r.fl[3:2];
                {result0, result1} = {r.v0, r.v1};
                result0_valid = 1'b1;
                result1_valid = (r.kind == K_ALU);
                if (r.kind == K_LOAD) begin
                    {load_pending, dcache_w_ready, dcache_rd} = {2'b11, r.rd0};
                    dcache_data = r.v1;
                    load_pc = LOAD_PC;
                end
            end
            K_CSR, K_CSRW: begin
                {uop0.is_csr, uop1.is_csr, csr_data} = {2'b11, r.v0};
                csr_ready = (r.kind == K_CSR);
            end
            K_DIV0, K_DIV1: begin
                // zero divisor leaves the dividend as remainder
                x0 = r.fl[1] ? ((b == 0) ? a : a % b) : q;
                x1 = x0;
                {src_a0, src_b0, src_a1, src_b1} = {a, b, a, b};
                if (r.kind == K_DIV0) begin
                    {uop0.is_div, uop0.div_rem} = {1'b1, r.fl[1]};
                end else begin
                    {uop1.is_div, uop1.div_rem} = {1'b1, r.fl[1]};
                end
            end
            default: begin
                {exception_in, cpu_interrupt} = (r.kind == K_EXC) ? 2'b10 : 2'b01;
                {ecode_in, badv_in, era_in} = {r.ecode, r.addr, r.addr + 32'h40};
            end
        endcase
    endtask

    initial begin
        idle_inputs();
        aresetn = 1'b0;
        fill_table();
        repeat (8) @(posedge clk);
        #2 aresetn = 1'b1;
        for (int i = 0; i < NROWS; i++) begin
            row = rows[i];
            we0 = row.kind inside {K_ALU, K_CSR, K_DIV0, K_LOAD};
            we1 = row.kind inside {K_ALU, K_DIV1};
            @(posedge clk);
            #2 drive_row(row, e0, e1);
            @(negedge clk);
            chk.check_allowin(!(row.kind inside {K_DIV0, K_DIV1}));
            while (!ex2_allowin) @(negedge clk);
            @(posedge clk);
            #2;
            chk.check_ports(we0, row.rd0, e0, PC0, we1, row.rd1, e1, PC1,
                            row.kind == K_LOAD, row.rd0, row.v1, LOAD_PC,
                            row.kind inside {K_EXC, K_INT},
                            row.kind == K_EXC && row.ecode == ECODE_TLBR);
            if (row.kind inside {K_EXC, K_INT})
                chk.commit(row.kind == K_EXC, row.ecode, row.addr, row.addr + 32'h40);
            idle_inputs();
            @(posedge clk);
            #2 chk.check_csr();
            if (we0) begin
                rf_raddr = row.rd0;
                #1 chk.check_reg(row.rd0, row.rd0 == 0 ? '0 : (row.kind == K_LOAD ? row.v1 : e0));
            end
            if (we1) begin
                rf_raddr = row.rd1;
                #1 chk.check_reg(row.rd1, e1);
            end
            rf_raddr = '0;
            #1 chk.check_reg(0, '0);
        end
        $display("%0d checks, %0d mismatches", chk.checks, chk.errors);
        if (chk.errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: testbench/wb_checker.sv
`timescale 1ns/10ps

module wb_checker #(
    parameter int XLEN = 32
) (
    input  logic                          ex2_allowin,
    input  logic                          wb0_we,
    input  logic [wb_pkg::REG_ADDR_W-1:0] wb0_rd,
    input  logic [XLEN-1:0]               wb0_data,
    input  logic [wb_pkg::ADDR_W-1:0]     wb0_pc,
    input  logic                          wb1_we,
    input  logic [wb_pkg::REG_ADDR_W-1:0] wb1_rd,
    input  logic [XLEN-1:0]               wb1_data,
    input  logic [wb_pkg::ADDR_W-1:0]     wb1_pc,
    input  logic                          wb2_we,
    input  logic [wb_pkg::REG_ADDR_W-1:0] wb2_rd,
    input  logic [XLEN-1:0]               wb2_data,
    input  logic [wb_pkg::ADDR_W-1:0]     wb2_pc,
    input  logic                          flush,
    input  logic [wb_pkg::ADDR_W-1:0]     redirect_pc,
    input  logic [wb_pkg::ADDR_W-1:0]     eentry,
    input  logic [wb_pkg::ADDR_W-1:0]     tlbrentry,
    input  logic [wb_pkg::ADDR_W-1:0]     csr_era,
    input  logic [wb_pkg::ADDR_W-1:0]     csr_badv,
    input  logic [wb_pkg::VPPN_W-1:0]     csr_vppn,
    input  wb_pkg::ecode_t                csr_ecode,
    input  logic [XLEN-1:0]               rf_rdata
);
    import wb_pkg::*;

    int                errors = 0;
    int                checks = 0;
    // expected exception CSR contents
    logic [ADDR_W-1:0] m_era   = '0;
    logic [ADDR_W-1:0] m_badv  = '0;
    logic [VPPN_W-1:0] m_vppn  = '0;
    ecode_t            m_ecode = ECODE_INT;

    function automatic logic addr_code(input ecode_t c);
        return c inside {ECODE_PIL, ECODE_PIS, ECODE_PIF, ECODE_PME, ECODE_PPI,
                         ECODE_ADEF, ECODE_ALE, ECODE_TLBR};
    endfunction

    // tlb refill and page faults
    function automatic logic page_code(input ecode_t c);
        return c inside {ECODE_PIL, ECODE_PIS, ECODE_PIF, ECODE_PME, ECODE_PPI, ECODE_TLBR};
    endfunction

    task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_ports(
        input logic e_we0, input logic [4:0] e_rd0, input logic [XLEN-1:0] e_d0,
        input logic [ADDR_W-1:0] e_pc0,
        input logic e_we1, input logic [4:0] e_rd1, input logic [XLEN-1:0] e_d1,
        input logic [ADDR_W-1:0] e_pc1,
        input logic e_we2, input logic [4:0] e_rd2, input logic [XLEN-1:0] e_d2,
        input logic [ADDR_W-1:0] e_pc2,
        input logic e_flush, input logic e_tlb
    );
        compare("wb0 we", wb0_we, e_we0);
        if (e_we0) begin
            compare("wb0 rd", wb0_rd, e_rd0);
            compare("wb0 data", wb0_data, e_d0);
            compare("wb0 pc", wb0_pc, e_pc0);
        end
        compare("wb1 we", wb1_we, e_we1);
        if (e_we1) begin
            compare("wb1 rd", wb1_rd, e_rd1);
            compare("wb1 data", wb1_data, e_d1);
            compare("wb1 pc", wb1_pc, e_pc1);
        end
        compare("wb2 we", wb2_we, e_we2);
        if (e_we2) begin
            compare("wb2 rd", wb2_rd, e_rd2);
            compare("wb2 data", wb2_data, e_d2);
            compare("wb2 pc", wb2_pc, e_pc2);
        end
        compare("flush", flush, e_flush);
        compare("redirect_pc", redirect_pc, e_tlb ? tlbrentry : eentry);
    endtask

    // stall only while a division is outstanding
    task automatic check_allowin(input logic e_allow);
        compare("ex2_allowin", ex2_allowin, e_allow);
    endtask

    // interrupt alone records INT and keeps badv
    task automatic commit(input logic is_exc, input ecode_t code,
                          input logic [ADDR_W-1:0] badv, input logic [ADDR_W-1:0] era);
        m_era   = era;
        m_ecode = is_exc ? code : ECODE_INT;
        if (is_exc && addr_code(code)) begin
            m_badv = badv;
        end
        if (is_exc && page_code(code)) begin
            m_vppn = badv[ADDR_W-1 -: VPPN_W];
        end
    endtask

    task automatic check_csr();
        compare("csr_ecode", csr_ecode, m_ecode);
        compare("csr_era", csr_era, m_era);
        compare("csr_badv", csr_badv, m_badv);
        compare("csr_vppn", csr_vppn, m_vppn);
    endtask

    task automatic check_reg(input logic [4:0] addr, input logic [XLEN-1:0] exp);
        compare($sformatf("register r%0d", addr), rf_rdata, exp);
    endtask

endmodule
